// File: compile.f
+incdir+sim
hw/letc_core_pkg.sv
hw/letc_core_forward_select.sv
hw/letc_core_bubble_wrap.sv
hw/letc_core_redirect.sv
hw/letc_core_adhesive.sv
sim/letc_core_adhesive_tb.sv

// File: Bender.yml
package:
  name: letc_core_adhesive

sources:
  # Package first, then the blocks, then the top level
  - hw/letc_core_pkg.sv
  - hw/letc_core_forward_select.sv
  - hw/letc_core_bubble_wrap.sv
  - hw/letc_core_redirect.sv
  - hw/letc_core_adhesive.sv

  # Testbench with its included model
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/letc_core_adhesive_tb.sv

// File: sim/letc_core_adhesive_model.svh
`ifndef LETC_CORE_ADHESIVE_MODEL_SVH
`define LETC_CORE_ADHESIVE_MODEL_SVH

// Model copy of the redirect fired flag
// Updated by the testbench at every rising edge
logic fired_model;

// Source can feed a request when it writes the register being read
// x0 never forwards
function automatic logic src_hits(input fwd_req_t req, input fwd_src_t src);
    if (!req.needed || req.rs_idx == 5'd0) begin
        return 1'b0;
    end
    if (!src.valid || !src.rd_we) begin
        return 1'b0;
    end
    return src.rd_idx == req.rs_idx;
endfunction

// Nearest eligible source wins
// first is the youngest stage the forwardee may take from
function automatic void pick_forward(
    input  fwd_req_t  req,
    input  stage_e    first,
    input  fwd_src_t  m1,
    input  fwd_src_t  m2,
    input  fwd_src_t  w,
    output fwd_resp_t resp,
    output logic      haz
);
    fwd_src_t win;
    logic     found;
    win   = '0;
    found = 1'b1;
    if (first <= M1 && src_hits(req, m1)) begin
        win = m1;
    end else if (first <= M2 && src_hits(req, m2)) begin
        win = m2;
    end else if (src_hits(req, w)) begin
        win = w;
    end else begin
        found = 1'b0;
    end
    resp = '0;
    // Load still in flight, no data, stall instead
    haz  = found && !win.data_valid;
    if (found && win.data_valid) begin
        resp.use_fwd = 1'b1;
        resp.data    = win.data;
    end
endfunction

// Stage is stalled when it or anything behind it holds
function automatic logic [NUM_STAGES-1:0] chain_stall(
    input logic [NUM_STAGES-1:0] ready,
    input logic [NUM_STAGES-1:0] haz
);
    logic [NUM_STAGES-1:0] stall;
    stall = '0;
    for (int s = 0; s < NUM_STAGES; s++) begin
        for (int t = s; t < NUM_STAGES; t++) begin
            if (!ready[t] || haz[t]) begin
                stall[s] = 1'b1;
            end
        end
    end
    return stall;
endfunction

// Taken branch redirects unless this branch already did
function automatic logic redirect_fires(input logic taken);
    return taken && !fired_model;
endfunction

// Redirect kills F1, F2, D and E
function automatic logic [NUM_STAGES-1:0] front_flush(input logic fire);
    return {3'b000, {4{fire}}};
endfunction

// Flag survives only while M1 stays put
function automatic logic next_fired_flag(input logic fire, input logic m1_stalled);
    if (!m1_stalled) begin
        return 1'b0;
    end
    return fired_model || fire;
endfunction

`endif

// File: sim/letc_core_adhesive_tb.sv
`timescale 1ns/1ps

module letc_core_adhesive_tb;

    import letc_core_pkg::*;

    localparam int          CLK_PERIOD     = 8;
    localparam int          RESET_CYCLES   = 4;
    localparam int          NUM_VECTORS    = 3000;
    // Reset plus every vector, with some slack
    localparam int          TIMEOUT_CYCLES = NUM_VECTORS + RESET_CYCLES + 96;
    localparam logic [31:0] SEED           = 32'h08b0cd33;

    logic                  clk;
    logic                  rst_n;
    logic [NUM_STAGES-1:0] stage_ready;
    logic [NUM_STAGES-1:0] stage_stall;
    logic [NUM_STAGES-1:0] stage_flush;
    logic                  branch_taken;
    pc_t                   branch_target;
    logic                  pc_load_en;
    pc_t                   pc_load_val;
    fwd_req_t              e_rs1_req;
    fwd_req_t              e_rs2_req;
    fwd_req_t              m1_rs2_req;
    fwd_req_t              m2_rs2_req;
    fwd_src_t              m1_src;
    fwd_src_t              m2_src;
    fwd_src_t              w_src;
    fwd_resp_t             e_rs1_fwd;
    fwd_resp_t             e_rs2_fwd;
    fwd_resp_t             m1_rs2_fwd;
    fwd_resp_t             m2_rs2_fwd;

    // Flag value the model takes at the next edge
    logic        fired_next;
    // Extra cycles the current branch stays in M1
    int          burst_left;
    // Event counts, each scenario has to show up at least once
    int          fwd_seen;
    int          hazard_seen;
    int          redirect_seen;
    int          held_seen;

    `include "letc_core_adhesive_model.svh"

    letc_core_adhesive dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .stage_ready   (stage_ready),
        .stage_stall   (stage_stall),
        .stage_flush   (stage_flush),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .pc_load_en    (pc_load_en),
        .pc_load_val   (pc_load_val),
        .e_rs1_req     (e_rs1_req),
        .e_rs2_req     (e_rs2_req),
        .m1_rs2_req    (m1_rs2_req),
        .m2_rs2_req    (m2_rs2_req),
        .m1_src        (m1_src),
        .m2_src        (m2_src),
        .w_src         (w_src),
        .e_rs1_fwd     (e_rs1_fwd),
        .e_rs2_fwd     (e_rs2_fwd),
        .m1_rs2_fwd    (m1_rs2_fwd),
        .m2_rs2_fwd    (m2_rs2_fwd)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_on_mismatch(input string name, input logic [63:0] expected,
                                    input logic [63:0] actual);
        $display("Mismatch %s expected 0x%0h actual 0x%0h", name, expected, actual);
        $display("Verification failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic abort_with(input string what);
        $display("%s", what);
        $display("Verification failed");
        $fatal(1, "stopped on failure");
    endtask

    // Small index range so sources and requests collide often
    function automatic fwd_req_t random_req();
        fwd_req_t r;
        r.needed = ($urandom % 4) != 0;
        r.rs_idx = reg_idx_t'($urandom % 8);
        return r;
    endfunction

    // About one in four sources is a load still waiting on memory
    function automatic fwd_src_t random_src();
        fwd_src_t s;
        s.valid      = ($urandom % 8) != 0;
        s.rd_we      = ($urandom % 4) != 0;
        s.rd_idx     = reg_idx_t'($urandom % 8);
        s.data_valid = ($urandom % 4) != 0;
        s.data       = $urandom;
        return s;
    endfunction

    task automatic drive_random();
        logic [NUM_STAGES-1:0] ready;
        for (int s = 0; s < NUM_STAGES; s++) begin
            ready[s] = ($urandom % 6) != 0;
        end
        stage_ready <= ready;
        e_rs1_req   <= random_req();
        e_rs2_req   <= random_req();
        m1_rs2_req  <= random_req();
        m2_rs2_req  <= random_req();
        m1_src      <= random_src();
        m2_src      <= random_src();
        w_src       <= random_src();
        // Same branch stays taken for a few cycles, as if held in M1
        if (burst_left > 0) begin
            burst_left--;
        end else if (($urandom % 3) == 0) begin
            branch_taken  <= 1'b1;
            branch_target <= $urandom & 32'hffff_fffc;
            burst_left    = $urandom % 6;
        end else begin
            branch_taken <= 1'b0;
        end
    endtask

    task automatic check_outputs();
        fwd_resp_t             exp_e_rs1;
        fwd_resp_t             exp_e_rs2;
        fwd_resp_t             exp_m1_rs2;
        fwd_resp_t             exp_m2_rs2;
        logic                  h_e1;
        logic                  h_e2;
        logic                  h_m1;
        logic                  h_m2;
        logic                  exp_fire;
        logic [NUM_STAGES-1:0] exp_haz;
        logic [NUM_STAGES-1:0] exp_raw;
        logic [NUM_STAGES-1:0] exp_flush;
        logic [NUM_STAGES-1:0] exp_stall;
        pick_forward(e_rs1_req, M1, m1_src, m2_src, w_src, exp_e_rs1, h_e1);
        pick_forward(e_rs2_req, M1, m1_src, m2_src, w_src, exp_e_rs2, h_e2);
        pick_forward(m1_rs2_req, M2, m1_src, m2_src, w_src, exp_m1_rs2, h_m1);
        pick_forward(m2_rs2_req, W, m1_src, m2_src, w_src, exp_m2_rs2, h_m2);
        // Hazard goes to the stage reading the operand
        exp_haz     = '0;
        exp_haz[E]  = h_e1 | h_e2;
        exp_haz[M1] = h_m1;
        exp_haz[M2] = h_m2;
        exp_raw     = chain_stall(stage_ready, exp_haz);
        exp_fire    = redirect_fires(branch_taken);
        exp_flush   = front_flush(exp_fire);
        exp_stall   = exp_raw & ~exp_flush;

        assert (e_rs1_fwd === exp_e_rs1)
            else stop_on_mismatch("e_rs1_fwd", exp_e_rs1, e_rs1_fwd);
        assert (e_rs2_fwd === exp_e_rs2)
            else stop_on_mismatch("e_rs2_fwd", exp_e_rs2, e_rs2_fwd);
        assert (m1_rs2_fwd === exp_m1_rs2)
            else stop_on_mismatch("m1_rs2_fwd", exp_m1_rs2, m1_rs2_fwd);
        assert (m2_rs2_fwd === exp_m2_rs2)
            else stop_on_mismatch("m2_rs2_fwd", exp_m2_rs2, m2_rs2_fwd);
        assert (stage_stall === exp_stall)
            else stop_on_mismatch("stage_stall", exp_stall, stage_stall);
        assert (stage_flush === exp_flush)
            else stop_on_mismatch("stage_flush", exp_flush, stage_flush);
        assert (pc_load_en === exp_fire)
            else stop_on_mismatch("pc_load_en", exp_fire, pc_load_en);
        // Target only matters while the redirect is out
        if (exp_fire) begin
            assert (pc_load_val === branch_target)
                else stop_on_mismatch("pc_load_val", branch_target, pc_load_val);
        end

        // M1 is never flushed, the raw bit is its stall
        fired_next = next_fired_flag(exp_fire, exp_raw[M1]);

        if (exp_e_rs1.use_fwd || exp_e_rs2.use_fwd || exp_m1_rs2.use_fwd
            || exp_m2_rs2.use_fwd) begin
            fwd_seen++;
        end
        if (exp_haz != '0) begin
            hazard_seen++;
        end
        if (exp_fire) begin
            redirect_seen++;
        end
        if (branch_taken && !exp_fire) begin
            held_seen++;
        end
    endtask

    // Ends a run that stops making progress
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        abort_with("Watchdog expired before all vectors were checked");
    end

    initial begin
        void'($urandom(SEED));
        rst_n         <= 1'b0;
        stage_ready   <= '1;
        branch_taken  <= 1'b0;
        branch_target <= '0;
        e_rs1_req     <= '0;
        e_rs2_req     <= '0;
        m1_rs2_req    <= '0;
        m2_rs2_req    <= '0;
        m1_src        <= '0;
        m2_src        <= '0;
        w_src         <= '0;
        fired_model   = 1'b0;
        fired_next    = 1'b0;
        burst_left    = 0;
        fwd_seen      = 0;
        hazard_seen   = 0;
        redirect_seen = 0;
        held_seen     = 0;

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        // Fresh out of reset, no branch, so no redirect and no flush
        @(negedge clk);
        assert (pc_load_en === 1'b0)
            else stop_on_mismatch("pc_load_en", 1'b0, pc_load_en);
        assert (stage_flush === '0)
            else stop_on_mismatch("stage_flush", '0, stage_flush);
        check_outputs();

        for (int n = 0; n < NUM_VECTORS; n++) begin
            @(posedge clk);
            fired_model = fired_next;
            drive_random();
            @(negedge clk);
            check_outputs();
        end

        assert (fwd_seen > 0) else abort_with("No forwarded operand was ever produced");
        assert (hazard_seen > 0) else abort_with("No load-use hazard was ever produced");
        assert (redirect_seen > 0) else abort_with("No branch redirect was ever produced");
        assert (held_seen > 0)
            else abort_with("No branch was ever held in a stalled M1 after redirecting");

        $display("Verification passed");
        $finish;
    end

endmodule : letc_core_adhesive_tb

// File: hw/letc_core_adhesive.sv
`timescale 1ns/1ps

module letc_core_adhesive (
    input  logic clk,
    input  logic rst_n,

    // Per-stage pipeline control
    input  logic [letc_core_pkg::NUM_STAGES-1:0] stage_ready,
    output logic [letc_core_pkg::NUM_STAGES-1:0] stage_stall,
    output logic [letc_core_pkg::NUM_STAGES-1:0] stage_flush,

    // Branch resolution from M1
    input  logic                     branch_taken,
    input  letc_core_pkg::pc_t       branch_target,

    // PC redirect to F1
    output logic                     pc_load_en,
    output letc_core_pkg::pc_t       pc_load_val,

    // Operand requests
    input  letc_core_pkg::fwd_req_t  e_rs1_req,
    input  letc_core_pkg::fwd_req_t  e_rs2_req,
    input  letc_core_pkg::fwd_req_t  m1_rs2_req,
    input  letc_core_pkg::fwd_req_t  m2_rs2_req,

    // Results offered by later stages
    input  letc_core_pkg::fwd_src_t  m1_src,
    input  letc_core_pkg::fwd_src_t  m2_src,
    input  letc_core_pkg::fwd_src_t  w_src,

    // Forwarding decisions
    output letc_core_pkg::fwd_resp_t e_rs1_fwd,
    output letc_core_pkg::fwd_resp_t e_rs2_fwd,
    output letc_core_pkg::fwd_resp_t m1_rs2_fwd,
    output letc_core_pkg::fwd_resp_t m2_rs2_fwd
);

    import letc_core_pkg::*;

    // Load-use hazards from forwarding into the stall chain
    logic [NUM_STAGES-1:0] hazard;
    // Redirect kill for F1 through E
    logic                  flush_front;
    // M1 is never flushed, so its output stall bit is the raw one
    logic                  m1_stalled;

    assign m1_stalled = stage_stall[M1];

    letc_core_forward_select u_forward (
        .e_rs1_req  (e_rs1_req),
        .e_rs2_req  (e_rs2_req),
        .m1_rs2_req (m1_rs2_req),
        .m2_rs2_req (m2_rs2_req),
        .m1_src     (m1_src),
        .m2_src     (m2_src),
        .w_src      (w_src),
        .e_rs1_fwd  (e_rs1_fwd),
        .e_rs2_fwd  (e_rs2_fwd),
        .m1_rs2_fwd (m1_rs2_fwd),
        .m2_rs2_fwd (m2_rs2_fwd),
        .hazard     (hazard)
    );

    letc_core_bubble_wrap u_bubble (
        .clk         (clk),
        .rst_n       (rst_n),
        .stage_ready (stage_ready),
        .hazard      (hazard),
        .flush_front (flush_front),
        .stage_stall (stage_stall),
        .stage_flush (stage_flush)
    );

    letc_core_redirect u_redirect (
        .clk           (clk),
        .rst_n         (rst_n),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .m1_stalled    (m1_stalled),
        .pc_load_en    (pc_load_en),
        .pc_load_val   (pc_load_val),
        .flush_front   (flush_front)
    );

endmodule : letc_core_adhesive

// File: hw/letc_core_redirect.sv
`timescale 1ns/1ps

module letc_core_redirect (
    input  logic               clk,
    input  logic               rst_n,

    // Branch outcome from M1
    input  logic               branch_taken,
    input  letc_core_pkg::pc_t branch_target,
    // M1 holds its instruction this cycle
    input  logic               m1_stalled,

    output logic               pc_load_en,
    output letc_core_pkg::pc_t pc_load_val,
    output logic               flush_front
);

    // Redirect for the branch now in M1 already went out
    logic fired_q;
    logic fire;

    // Only the first cycle of a taken branch redirects
    assign fire = branch_taken && !fired_q;

    assign pc_load_en  = fire;
    assign flush_front = fire;

    // Target is only looked at when pc_load_en is high
    assign pc_load_val = branch_target;

    // Remember the redirect while the same branch sits in M1
    // Once M1 moves on the next instruction gets a fresh chance
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fired_q <= 1'b0;
        end else if (!m1_stalled) begin
            fired_q <= 1'b0;
        end else if (fire) begin
            fired_q <= 1'b1;
        end
    end

    // A branch stuck in M1 redirects once, not every cycle it waits
    single_redirect_when_stalled: assert property (
        @(posedge clk) disable iff (!rst_n)
        (pc_load_en && m1_stalled) |=> !pc_load_en
    );

endmodule : letc_core_redirect

// File: hw/letc_core_bubble_wrap.sv
`timescale 1ns/1ps

module letc_core_bubble_wrap (
    input  logic clk,
    input  logic rst_n,

    input  logic [letc_core_pkg::NUM_STAGES-1:0] stage_ready,
    input  logic [letc_core_pkg::NUM_STAGES-1:0] hazard,
    input  logic                                 flush_front,

    output logic [letc_core_pkg::NUM_STAGES-1:0] stage_stall,
    output logic [letc_core_pkg::NUM_STAGES-1:0] stage_flush
);

    import letc_core_pkg::*;

    // Stage wants to hold this cycle
    logic [NUM_STAGES-1:0] hold;
    // Stall before the flush override
    logic [NUM_STAGES-1:0] stall_raw;

    always_comb begin
        hold = ~stage_ready | hazard;

        // A hold anywhere backs up every stage in front of it
        stall_raw[W] = hold[W];
        for (int i = W - 1; i >= 0; i--) begin
            stall_raw[i] = hold[i] | stall_raw[i+1];
        end
    end

    always_comb begin
        // Branch resolves in M1, so everything younger is wrong path
        stage_flush = '0;
        for (int i = F1; i <= E; i++) begin
            stage_flush[i] = flush_front;
        end

        // Killed instructions are not worth holding
        stage_stall = stall_raw & ~stage_flush;
    end

    // Stall has to propagate backward
    // A stalled stage means the one in front is stalled too, or being flushed
    stall_monotone: assert property (
        @(posedge clk) disable iff (!rst_n)
        (stage_stall[NUM_STAGES-1:1]
            & ~(stage_stall[NUM_STAGES-2:0] | stage_flush[NUM_STAGES-2:0])) == '0
    );

endmodule : letc_core_bubble_wrap

// File: hw/letc_core_forward_select.sv
`timescale 1ns/1ps

module letc_core_forward_select (
    input  letc_core_pkg::fwd_req_t  e_rs1_req,
    input  letc_core_pkg::fwd_req_t  e_rs2_req,
    input  letc_core_pkg::fwd_req_t  m1_rs2_req,
    input  letc_core_pkg::fwd_req_t  m2_rs2_req,

    input  letc_core_pkg::fwd_src_t  m1_src,
    input  letc_core_pkg::fwd_src_t  m2_src,
    input  letc_core_pkg::fwd_src_t  w_src,

    output letc_core_pkg::fwd_resp_t e_rs1_fwd,
    output letc_core_pkg::fwd_resp_t e_rs2_fwd,
    output letc_core_pkg::fwd_resp_t m1_rs2_fwd,
    output letc_core_pkg::fwd_resp_t m2_rs2_fwd,

    output logic [letc_core_pkg::NUM_STAGES-1:0] hazard
);

    import letc_core_pkg::*;

    // Eligible sources per forwardee
    // Bit 0 is M1, bit 1 is M2, bit 2 is W
    localparam logic [2:0] ELIG_E  = 3'b111;
    localparam logic [2:0] ELIG_M1 = 3'b110;
    localparam logic [2:0] ELIG_M2 = 3'b100;

    logic e_rs1_haz;
    logic e_rs2_haz;
    logic m1_rs2_haz;
    logic m2_rs2_haz;

    // x0 is hardwired, never forward it
    function automatic logic src_match(input fwd_req_t req, input fwd_src_t src);
        return req.needed && (req.rs_idx != '0) && src.valid && src.rd_we
            && (src.rd_idx == req.rs_idx);
    endfunction

    // Nearest eligible match wins
    // A winner without data means a load in flight, so stall instead
    function automatic void resolve(
        input  fwd_req_t  req,
        input  fwd_src_t  near_src,
        input  fwd_src_t  mid_src,
        input  fwd_src_t  far_src,
        input  logic [2:0] eligible,
        output fwd_resp_t resp,
        output logic      stall
    );
        fwd_src_t src [3];
        logic     found;
        src[0] = near_src;
        src[1] = mid_src;
        src[2] = far_src;
        found  = 1'b0;
        resp   = '0;
        stall  = 1'b0;
        for (int i = 0; i < 3; i++) begin
            if (!found && eligible[i] && src_match(req, src[i])) begin
                found = 1'b1;
                if (src[i].data_valid) begin
                    resp.use_fwd = 1'b1;
                    resp.data    = src[i].data;
                end else begin
                    stall = 1'b1;
                end
            end
        end
    endfunction

    always_comb begin
        resolve(e_rs1_req,  m1_src, m2_src, w_src, ELIG_E,  e_rs1_fwd,  e_rs1_haz);
        resolve(e_rs2_req,  m1_src, m2_src, w_src, ELIG_E,  e_rs2_fwd,  e_rs2_haz);
        resolve(m1_rs2_req, m1_src, m2_src, w_src, ELIG_M1, m1_rs2_fwd, m1_rs2_haz);
        resolve(m2_rs2_req, m1_src, m2_src, w_src, ELIG_M2, m2_rs2_fwd, m2_rs2_haz);

        // Hazards land on the stage that reads the operand
        // Front end and W never wait on a forwarded value
        hazard     = '0;
        hazard[E]  = e_rs1_haz | e_rs2_haz;
        hazard[M1] = m1_rs2_haz;
        hazard[M2] = m2_rs2_haz;
    end

endmodule : letc_core_forward_select

// File: hw/letc_core_pkg.sv
package letc_core_pkg;

    // Pipeline depth, F1 through W
    localparam int NUM_STAGES = 7;

    // Stage positions in every per-stage vector
    // Bit 0 is the front of the pipe
    typedef enum logic [2:0] {
        F1 = 3'd0,
        F2 = 3'd1,
        D  = 3'd2,
        E  = 3'd3,
        M1 = 3'd4,
        M2 = 3'd5,
        W  = 3'd6
    } stage_e;

    // RV32 widths
    typedef logic [31:0] pc_t;
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // What a later stage can hand back to an earlier one
    typedef struct packed {
        // Stage holds a real instruction, not a bubble
        logic     valid;
        // Instruction writes its destination register
        logic     rd_we;
        reg_idx_t rd_idx;
        // Low while a load is still waiting on memory
        logic     data_valid;
        word_t    data;
    } fwd_src_t;

    // One operand that a stage wants to read
    typedef struct packed {
        logic     needed;
        reg_idx_t rs_idx;
    } fwd_req_t;

    // Forwarding decision for one operand
    // With use_fwd low the stage keeps its register file value
    typedef struct packed {
        logic  use_fwd;
        word_t data;
    } fwd_resp_t;

endpackage : letc_core_pkg
